//--- sources.f
logic/mem_map_pkg.sv
logic/sdram_slot_pkg.sv
logic/frac_cen.sv
logic/rom_loader.sv
logic/slot_arbiter.sv
logic/game_mem_top.sv
verification/game_mem_checker.sv
verification/game_mem_tb.sv

//--- Bender.yml
package:
  name: game_mem

sources:
  - logic/mem_map_pkg.sv
  - logic/sdram_slot_pkg.sv
  - logic/frac_cen.sv
  - logic/rom_loader.sv
  - logic/slot_arbiter.sv
  - logic/game_mem_top.sv
  - target: test
    files:
      - verification/game_mem_checker.sv
      - verification/game_mem_tb.sv

//--- verification/game_mem_tb.sv
// Testbench for the memory top level, runs the stimulus phases against an SDRAM responder model
`timescale 1ns/1ps

module game_mem_tb;
    import mem_map_pkg::*;
    import sdram_slot_pkg::*;

    localparam int NUM_BYTES    = 12;
    localparam int RESET_CYCLES = 5;
    localparam int CEN_CYCLES   = 20 * int'(CEN_DEN) + 2;
    localparam int DL_CYCLES    = NUM_BYTES * 10;
    // Nine slot accesses of at most 10 cycles, plus the gaps between phases
    localparam int SLOT_CYCLES  = 9 * 10 + 30;
    localparam int CYCLE_LIMIT  = (RESET_CYCLES + CEN_CYCLES + DL_CYCLES + SLOT_CYCLES) * 3 / 2;

    logic                 VB;
    logic                 rst_n;
    logic                 downloading;
    logic [DL_AW-1:0]     ioctl_addr;
    logic [7:0]           ioctl_data;
    logic                 ioctl_wr;
    logic [SDRAM_AW-1:0]  prog_addr;
    logic [7:0]           prog_data;
    logic [1:0]           prog_mask, prog_bank;
    logic                 prog_we;
    logic                 rom_cs, ram_cs, gfx_cs, snd_cs;
    logic                 rom_ok, ram_ok, gfx_ok, snd_ok;
    logic [ROM_AW-1:0]    rom_addr;
    logic [RAM_AW-1:0]    ram_addr;
    logic [GFX_AW-1:0]    gfx_addr;
    logic [SND_AW-1:0]    snd_addr;
    logic                 ram_vram, ram_rnw;
    logic [15:0]          ram_din, rom_data, ram_data;
    logic [1:0]           ram_dsn;
    logic [31:0]          gfx_data;
    logic [7:0]           snd_data;
    logic                 sdram_ack, data_rdy, sdram_req, sdram_rnw;
    logic [SDRAM_RDW-1:0] data_read;
    logic [SDRAM_AW-1:0]  sdram_addr;
    logic [1:0]           sdram_bank, sdram_wrmask;
    logic [SDRAM_WDW-1:0] data_write;
    logic                 cpu_cen, cen_done;
    int                   checks, errors;
    int                   cycles = 0;

    game_mem_top game_mem_top_i (.*);

    game_mem_checker game_mem_checker_i (.*);

    initial begin
        VB = 1'b0;
        forever #4 VB = ~VB;
    end

    always @(posedge VB) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: no finish within %0d cycles (checks %0d, errors %0d)",
                     CYCLE_LIMIT, checks, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [SDRAM_RDW-1:0] sdram_word(input logic [SDRAM_AW-1:0] a);
        return ~{10'd0, a} ^ 32'h5a5a_0000;
    endfunction

    // SDRAM model, acks loader writes and slot requests, data only for slot requests
    initial begin : sdram_model
        logic slot_access;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge VB);
            if (sdram_req || prog_we) begin
                slot_access = sdram_req;
                repeat ($urandom_range(3, 1) - 1) @(posedge VB);
                sdram_ack <= 1'b1;
                @(posedge VB);
                sdram_ack <= 1'b0;
                if (slot_access) begin
                    repeat ($urandom_range(4, 1) - 1) @(posedge VB);
                    data_rdy  <= 1'b1;
                    data_read <= sdram_word(sdram_addr);
                    @(posedge VB);
                    data_rdy <= 1'b0;
                end
            end
        end
    end

    task automatic send_byte(input logic [DL_AW-1:0] a, input logic [7:0] d);
        @(posedge VB);
        ioctl_addr <= a;
        ioctl_data <= d;
        ioctl_wr   <= 1'b1;
        @(posedge VB);
        ioctl_wr <= 1'b0;
        @(posedge VB);
        // No back-pressure on the loader port, so hold off until the write is done
        while (prog_we) @(posedge VB);
    endtask

    task automatic wait_ok(input logic [3:0] want);
        do begin
            @(posedge VB);
        end while ({snd_ok, gfx_ok, ram_ok, rom_ok} != want);
    endtask

    initial begin
        logic [DL_AW-1:0] a;
        void'($urandom(32'h4f7d));
        rst_n       <= 1'b0;
        downloading <= 1'b0;
        ioctl_addr  <= '0;
        ioctl_data  <= '0;
        ioctl_wr    <= 1'b0;
        {rom_cs, ram_cs, gfx_cs, snd_cs} <= '0;
        rom_addr    <= '0;
        ram_addr    <= '0;
        gfx_addr    <= '0;
        snd_addr    <= '0;
        ram_vram    <= 1'b0;
        ram_rnw     <= 1'b1;
        ram_din     <= '0;
        ram_dsn     <= 2'b11;
        repeat (RESET_CYCLES) @(posedge VB);
        rst_n <= 1'b1;

        // Clock enable windows are counted by the checker
        while (cen_done !== 1'b1) @(posedge VB);

        // Download with a slot waiting, which must not reach the SDRAM
        @(posedge VB);
        downloading <= 1'b1;
        rom_cs      <= 1'b1;
        rom_addr    <= ROM_AW'($urandom);
        send_byte(CPU_ROM_BYTES - 1, 8'($urandom));
        send_byte(CPU_ROM_BYTES, 8'($urandom));
        for (int i = 0; i < NUM_BYTES - 2; i++) begin
            if (i % 2 == 0) begin
                a = DL_AW'($urandom_range(CPU_ROM_BYTES - 1, 0));
            end else begin
                a = CPU_ROM_BYTES + DL_AW'($urandom_range((1 << DL_AW) - 1 - CPU_ROM_BYTES, 0));
            end
            send_byte(a, 8'($urandom));
        end
        @(posedge VB);
        downloading <= 1'b0;
        rom_cs      <= 1'b0;

        // All four clients at once
        @(posedge VB);
        {rom_cs, ram_cs, gfx_cs, snd_cs} <= 4'hf;
        rom_addr <= ROM_AW'($urandom);
        ram_addr <= RAM_AW'($urandom);
        gfx_addr <= GFX_AW'($urandom);
        snd_addr <= SND_AW'($urandom);
        wait_ok(4'b1111);

        // New addresses with cs held, RAM moves over to VRAM
        @(posedge VB);
        rom_addr <= rom_addr + ROM_AW'($urandom_range(255, 1));
        ram_addr <= ram_addr + RAM_AW'($urandom_range(255, 1));
        ram_vram <= 1'b1;
        gfx_addr <= gfx_addr + GFX_AW'($urandom_range(255, 1));
        snd_addr <= snd_addr + SND_AW'($urandom_range(255, 1));
        wait_ok(4'b0000);
        wait_ok(4'b1111);
        @(posedge VB);
        {rom_cs, ram_cs, gfx_cs, snd_cs} <= '0;
        wait_ok(4'b0000);

        // RAM write
        @(posedge VB);
        ram_cs   <= 1'b1;
        ram_rnw  <= 1'b0;
        ram_vram <= 1'b0;
        ram_addr <= RAM_AW'($urandom);
        ram_din  <= 16'($urandom);
        ram_dsn  <= 2'($urandom_range(2, 0));
        wait_ok(4'b0010);
        @(posedge VB);
        ram_cs  <= 1'b0;
        ram_rnw <= 1'b1;
        ram_dsn <= 2'b11;
        wait_ok(4'b0000);

        repeat (2) @(posedge VB);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verification/game_mem_checker.sv
// Watches the memory top level, compares its outputs against reference rules and counts errors
`timescale 1ns/1ps

module game_mem_checker (
    input  logic                              VB,
    input  logic                              rst_n,
    input  logic                              downloading,
    input  logic [mem_map_pkg::DL_AW-1:0]     ioctl_addr,
    input  logic [7:0]                        ioctl_data,
    input  logic                              ioctl_wr,
    input  logic [mem_map_pkg::SDRAM_AW-1:0]  prog_addr,
    input  logic [7:0]                        prog_data,
    input  logic [1:0]                        prog_mask,
    input  logic [1:0]                        prog_bank,
    input  logic                              prog_we,
    input  logic                              rom_cs, ram_cs, gfx_cs, snd_cs,
    input  logic                              rom_ok, ram_ok, gfx_ok, snd_ok,
    input  logic [sdram_slot_pkg::ROM_AW-1:0] rom_addr,
    input  logic [sdram_slot_pkg::RAM_AW-1:0] ram_addr,
    input  logic [sdram_slot_pkg::GFX_AW-1:0] gfx_addr,
    input  logic [sdram_slot_pkg::SND_AW-1:0] snd_addr,
    input  logic                              ram_vram,
    input  logic                              ram_rnw,
    input  logic [15:0]                       ram_din,
    input  logic [1:0]                        ram_dsn,
    input  logic [15:0]                       rom_data, ram_data,
    input  logic [31:0]                       gfx_data,
    input  logic [7:0]                        snd_data,
    input  logic                              sdram_req,
    input  logic [mem_map_pkg::SDRAM_AW-1:0]  sdram_addr,
    input  logic [1:0]                        sdram_bank, sdram_wrmask,
    input  logic                              sdram_rnw,
    input  logic [mem_map_pkg::SDRAM_WDW-1:0] data_write,
    input  logic                              cpu_cen,
    output logic                              cen_done,
    output int                                checks,
    output int                                errors
);
    import mem_map_pkg::*;
    import sdram_slot_pkg::*;

    localparam int WINDOWS = 20;

    logic [NUM_SLOTS-1:0] cs_v, ok_v, cs_d, ok_d, served_read;
    logic [22:0]          key_v [NUM_SLOTS];
    logic [22:0]          key_d [NUM_SLOTS];
    logic [22:0]          served_key [NUM_SLOTS];
    logic [31:0]          data_v [NUM_SLOTS];
    logic                 rst_d, req_d, we_d, dl_d, rnw_d;
    logic [1:0]           dsn_d;
    logic [15:0]          din_d;
    logic [DL_AW-1:0]     exp_byte_addr;
    logic [7:0]           exp_byte;
    int                   cen_count, cen_cycle, cen_windows;
    string                data_name [NUM_SLOTS] = '{"rom_data", "ram_data", "gfx_data", "snd_data"};

    initial begin
        checks = 0;
        errors = 0;
    end

    assign cen_done = cen_windows == WINDOWS;

    // Slot views indexed by slot number
    // RAM key carries the VRAM select on top
    always_comb begin
        cs_v = {snd_cs, gfx_cs, ram_cs, rom_cs};
        ok_v = {snd_ok, gfx_ok, ram_ok, rom_ok};
        key_v[SLOT_CPU_ROM]  = 23'(rom_addr);
        key_v[SLOT_RAM]      = 23'({ram_vram, ram_addr});
        key_v[SLOT_GFX]      = 23'(gfx_addr);
        key_v[SLOT_SND]      = 23'(snd_addr);
        data_v[SLOT_CPU_ROM] = {16'd0, rom_data};
        data_v[SLOT_RAM]     = {16'd0, ram_data};
        data_v[SLOT_GFX]     = gfx_data;
        data_v[SLOT_SND]     = {24'd0, snd_data};
    end

    // Bank 1 below the CPU program size, rebased bank 0 above it
    function automatic logic [SDRAM_AW-1:0] place_addr(input logic [DL_AW-1:0] a);
        logic [DL_AW-1:0] off;
        off = (a < CPU_ROM_BYTES) ? a : a - CPU_ROM_BYTES;
        return SDRAM_AW'(off / 2);
    endfunction

    function automatic logic [SDRAM_AW-1:0] slot_addr(input int s, input logic [22:0] key);
        case (s)
            SLOT_CPU_ROM: return SDRAM_AW'(key);
            SLOT_RAM:     return (key[RAM_AW] ? VRAM_OFFSET : RAM_OFFSET) + SDRAM_AW'(key[RAM_AW-1:0]);
            SLOT_GFX:     return GFX_OFFSET + SDRAM_AW'(key);
            default:      return SOUND_OFFSET + SDRAM_AW'(key);
        endcase
    endfunction

    // Responder word for an address, cut to the slot width
    function automatic logic [31:0] slot_data(input int s, input logic [SDRAM_AW-1:0] a);
        logic [31:0] word;
        word = ~{10'd0, a} ^ 32'h5a5a_0000;
        case (s)
            SLOT_GFX: return word;
            SLOT_SND: return {24'd0, word[7:0]};
            default:  return {16'd0, word[15:0]};
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_fault(input string msg);
        errors++;
        $display("At %0t: %s", $time, msg);
    endtask

    always @(posedge VB) begin
        int   grant;
        logic wr;
        if (rst_d === 1'b0) begin
            compare_value("sdram_req/prog_we/cpu_cen/ok after reset",
                          {sdram_req, prog_we, cpu_cen, ok_v}, '0);
        end
        if (!rst_n) begin
            cen_count   <= 0;
            cen_cycle   <= 0;
            cen_windows <= 0;
        end else if (rst_d) begin
            if (cen_windows < WINDOWS) begin
                if (cen_cycle == CEN_DEN - 1) begin
                    compare_value("cpu_cen pulses per window", cen_count + cpu_cen, CEN_NUM);
                    cen_windows <= cen_windows + 1;
                    cen_cycle   <= 0;
                    cen_count   <= 0;
                end else begin
                    cen_cycle <= cen_cycle + 1;
                    cen_count <= cen_count + cpu_cen;
                end
            end
            if (downloading && ioctl_wr && !prog_we) begin
                exp_byte_addr <= ioctl_addr;
                exp_byte      <= ioctl_data;
            end
            if (prog_we && !we_d) begin
                compare_value("prog_addr", prog_addr, place_addr(exp_byte_addr));
                compare_value("prog_bank", prog_bank, (exp_byte_addr < CPU_ROM_BYTES) ? 1 : 0);
                compare_value("prog_mask", prog_mask, exp_byte_addr[0] ? 2'b01 : 2'b10);
                compare_value("prog_data", prog_data, exp_byte);
            end
            // Grant decided one cycle before the rise, from the inputs seen then
            if (sdram_req && !req_d) begin
                grant = -1;
                for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
                    if (cs_d[i] && !ok_d[i]) begin
                        grant = i;
                    end
                end
                if (dl_d) begin
                    report_fault("sdram_req rose while a download was running");
                end
                if (grant < 0) begin
                    report_fault("sdram_req rose with no slot pending");
                end else begin
                    wr = (grant == SLOT_RAM) && !rnw_d;
                    compare_value("sdram_addr", sdram_addr, slot_addr(grant, key_d[grant]));
                    compare_value("sdram_bank", sdram_bank, (grant == SLOT_CPU_ROM) ? 1 : 0);
                    compare_value("sdram_rnw", sdram_rnw, !wr);
                    compare_value("sdram_wrmask", sdram_wrmask, wr ? dsn_d : 2'b11);
                    if (wr) begin
                        compare_value("data_write", data_write, din_d);
                    end
                    served_key[grant]  <= key_d[grant];
                    served_read[grant] <= !wr;
                end
            end
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (ok_v[i] && !ok_d[i] && served_read[i]) begin
                    compare_value(data_name[i], data_v[i],
                                  slot_data(i, slot_addr(i, served_key[i])));
                end
                if (ok_v[i] && !(cs_d[i] && key_d[i] == served_key[i])) begin
                    report_fault("ok stayed high after cs fell or the address changed");
                end
            end
        end
        rst_d <= rst_n;
        req_d <= sdram_req;
        we_d  <= prog_we;
        dl_d  <= downloading;
        cs_d  <= cs_v;
        ok_d  <= ok_v;
        key_d <= key_v;
        rnw_d <= ram_rnw;
        dsn_d <= ram_dsn;
        din_d <= ram_din;
    end

endmodule

//--- logic/game_mem_top.sv
// Memory side of the game board, joins the CPU enable, the ROM download writer and the slot mux
`timescale 1ns/1ps

module game_mem_top (
    input  logic                              VB,
    input  logic                              rst_n,
    input  logic                              downloading,
    // Loader port
    input  logic [mem_map_pkg::DL_AW-1:0]     ioctl_addr,
    input  logic [7:0]                        ioctl_data,
    input  logic                              ioctl_wr,
    output logic [mem_map_pkg::SDRAM_AW-1:0]  prog_addr,
    output logic [7:0]                        prog_data,
    output logic [1:0]                        prog_mask,
    output logic [1:0]                        prog_bank,
    output logic                              prog_we,
    // CPU ROM slot
    input  logic                              rom_cs,
    input  logic [sdram_slot_pkg::ROM_AW-1:0] rom_addr,
    output logic [15:0]                       rom_data,
    output logic                              rom_ok,
    // RAM slot
    input  logic                              ram_cs,
    input  logic                              ram_vram,
    input  logic [sdram_slot_pkg::RAM_AW-1:0] ram_addr,
    input  logic                              ram_rnw,
    input  logic [15:0]                       ram_din,
    input  logic [1:0]                        ram_dsn,
    output logic [15:0]                       ram_data,
    output logic                              ram_ok,
    // Graphics slot
    input  logic                              gfx_cs,
    input  logic [sdram_slot_pkg::GFX_AW-1:0] gfx_addr,
    output logic [31:0]                       gfx_data,
    output logic                              gfx_ok,
    // Sound slot
    input  logic                              snd_cs,
    input  logic [sdram_slot_pkg::SND_AW-1:0] snd_addr,
    output logic [7:0]                        snd_data,
    output logic                              snd_ok,
    // SDRAM controller
    input  logic                              sdram_ack,
    input  logic                              data_rdy,
    input  logic [mem_map_pkg::SDRAM_RDW-1:0] data_read,
    output logic                              sdram_req,
    output logic [mem_map_pkg::SDRAM_AW-1:0]  sdram_addr,
    output logic [1:0]                        sdram_bank,
    output logic                              sdram_rnw,
    output logic [1:0]                        sdram_wrmask,
    output logic [mem_map_pkg::SDRAM_WDW-1:0] data_write,
    // CPU enable
    output logic                              cpu_cen
);

    frac_cen frac_cen_i (
        .VB      (VB),
        .rst_n   (rst_n),
        .cpu_cen (cpu_cen)
    );

    // Shares sdram_ack with the mux, which stays quiet while downloading
    rom_loader rom_loader_i (
        .VB          (VB),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_bank   (prog_bank),
        .prog_we     (prog_we)
    );

    slot_arbiter slot_arbiter_i (
        .VB           (VB),
        .rst_n        (rst_n),
        .downloading  (downloading),
        .rom_cs       (rom_cs),
        .rom_addr     (rom_addr),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .ram_cs       (ram_cs),
        .ram_vram     (ram_vram),
        .ram_addr     (ram_addr),
        .ram_rnw      (ram_rnw),
        .ram_din      (ram_din),
        .ram_dsn      (ram_dsn),
        .ram_data     (ram_data),
        .ram_ok       (ram_ok),
        .gfx_cs       (gfx_cs),
        .gfx_addr     (gfx_addr),
        .gfx_data     (gfx_data),
        .gfx_ok       (gfx_ok),
        .snd_cs       (snd_cs),
        .snd_addr     (snd_addr),
        .snd_data     (snd_data),
        .snd_ok       (snd_ok),
        .sdram_ack    (sdram_ack),
        .data_rdy     (data_rdy),
        .data_read    (data_read),
        .sdram_req    (sdram_req),
        .sdram_addr   (sdram_addr),
        .sdram_bank   (sdram_bank),
        .sdram_rnw    (sdram_rnw),
        .sdram_wrmask (sdram_wrmask),
        .data_write   (data_write)
    );

endmodule

//--- logic/slot_arbiter.sv
// Fixed-priority SDRAM slot multiplexer, translates client addresses and returns read data
`timescale 1ns/1ps

module slot_arbiter (
    input  logic                              VB,
    input  logic                              rst_n,
    input  logic                              downloading,
    // CPU ROM slot
    input  logic                              rom_cs,
    input  logic [sdram_slot_pkg::ROM_AW-1:0] rom_addr,
    output logic [15:0]                       rom_data,
    output logic                              rom_ok,
    // RAM slot
    input  logic                              ram_cs,
    input  logic                              ram_vram,
    input  logic [sdram_slot_pkg::RAM_AW-1:0] ram_addr,
    input  logic                              ram_rnw,
    input  logic [15:0]                       ram_din,
    input  logic [1:0]                        ram_dsn,
    output logic [15:0]                       ram_data,
    output logic                              ram_ok,
    // Graphics slot
    input  logic                              gfx_cs,
    input  logic [sdram_slot_pkg::GFX_AW-1:0] gfx_addr,
    output logic [31:0]                       gfx_data,
    output logic                              gfx_ok,
    // Sound slot
    input  logic                              snd_cs,
    input  logic [sdram_slot_pkg::SND_AW-1:0] snd_addr,
    output logic [7:0]                        snd_data,
    output logic                              snd_ok,
    // SDRAM controller
    input  logic                              sdram_ack,
    input  logic                              data_rdy,
    input  logic [mem_map_pkg::SDRAM_RDW-1:0] data_read,
    output logic                              sdram_req,
    output logic [mem_map_pkg::SDRAM_AW-1:0]  sdram_addr,
    output logic [1:0]                        sdram_bank,
    output logic                              sdram_rnw,
    output logic [1:0]                        sdram_wrmask,
    output logic [mem_map_pkg::SDRAM_WDW-1:0] data_write
);
    import mem_map_pkg::*;
    import sdram_slot_pkg::*;

    arb_state_e           state;
    slot_e                cur_slot;
    slot_e                grant;
    logic [NUM_SLOTS-1:0] cs_v;
    logic [NUM_SLOTS-1:0] match_v;
    logic [NUM_SLOTS-1:0] ok_q;
    logic [NUM_SLOTS-1:0] pending;
    logic [ROM_AW-1:0]    rom_addr_q;
    logic [RAM_AW:0]      ram_addr_q;
    logic [GFX_AW-1:0]    gfx_addr_q;
    logic [SND_AW-1:0]    snd_addr_q;
    logic [SDRAM_AW-1:0]  next_addr;
    logic                 ram_write;
    logic                 start;
    logic                 done;

    assign cs_v = {snd_cs, gfx_cs, ram_cs, rom_cs};

    // Address served last, RAM also keeps its VRAM select
    assign match_v[SLOT_CPU_ROM] = rom_addr == rom_addr_q;
    assign match_v[SLOT_RAM]     = {ram_vram, ram_addr} == ram_addr_q;
    assign match_v[SLOT_GFX]     = gfx_addr == gfx_addr_q;
    assign match_v[SLOT_SND]     = snd_addr == snd_addr_q;

    assign pending = cs_v & ~ok_q;
    assign start   = (state == ARB_IDLE) && !downloading && (|pending);
    assign done    = (state == ARB_WAIT_DATA) && data_rdy;

    assign rom_ok = ok_q[SLOT_CPU_ROM];
    assign ram_ok = ok_q[SLOT_RAM];
    assign gfx_ok = ok_q[SLOT_GFX];
    assign snd_ok = ok_q[SLOT_SND];

    // Lowest pending slot wins
    always_comb begin
        grant = SLOT_CPU_ROM;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                grant = slot_e'(i);
            end
        end
    end

    // Region offset plus client address, CPU ROM starts at word 0 of bank 1
    always_comb begin
        case (grant)
            SLOT_CPU_ROM: next_addr = SDRAM_AW'(rom_addr);
            SLOT_RAM:     next_addr = (ram_vram ? VRAM_OFFSET : RAM_OFFSET) + SDRAM_AW'(ram_addr);
            SLOT_GFX:     next_addr = GFX_OFFSET + gfx_addr;
            default:      next_addr = SOUND_OFFSET + SDRAM_AW'(snd_addr);
        endcase
    end

    assign ram_write = (grant == SLOT_RAM) && !ram_rnw;

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            state     <= ARB_IDLE;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (start) begin
                        state     <= ARB_WAIT_ACK;
                        sdram_req <= 1'b1;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        state     <= ARB_WAIT_DATA;
                        sdram_req <= 1'b0;
                    end
                end
                ARB_WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Request fields latched at grant, stable for the whole access
    always_ff @(posedge VB) begin
        if (start) begin
            cur_slot     <= grant;
            sdram_addr   <= next_addr;
            sdram_bank   <= (grant == SLOT_CPU_ROM) ? 2'b01 : 2'b00;
            sdram_rnw    <= !ram_write;
            sdram_wrmask <= ram_write ? ram_dsn : 2'b11;
            data_write   <= ram_din;
            case (grant)
                SLOT_CPU_ROM: rom_addr_q <= rom_addr;
                SLOT_RAM:     ram_addr_q <= {ram_vram, ram_addr};
                SLOT_GFX:     gfx_addr_q <= gfx_addr;
                default:      snd_addr_q <= snd_addr;
            endcase
        end
    end

    // Narrow slots take the low lanes of the read word
    always_ff @(posedge VB) begin
        if (done) begin
            case (cur_slot)
                SLOT_CPU_ROM: rom_data <= data_read[15:0];
                SLOT_RAM:     ram_data <= data_read[15:0];
                SLOT_GFX:     gfx_data <= data_read;
                default:      snd_data <= data_read[7:0];
            endcase
        end
    end

    // ok only rises if the client still wants the address that was fetched
    always_ff @(posedge VB) begin
        if (!rst_n) begin
            ok_q <= '0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (done && (cur_slot == slot_e'(i))) begin
                    ok_q[i] <= cs_v[i] && match_v[i];
                end else if (!cs_v[i] || !match_v[i]) begin
                    ok_q[i] <= 1'b0;
                end
            end
        end
    end

endmodule

//--- logic/rom_loader.sv
// ROM download writer, turns loader bytes into masked SDRAM word writes placed by region
`timescale 1ns/1ps

module rom_loader (
    input  logic                            VB,
    input  logic                            rst_n,
    input  logic                            downloading,
    input  logic [mem_map_pkg::DL_AW-1:0]   ioctl_addr,
    input  logic [7:0]                      ioctl_data,
    input  logic                            ioctl_wr,
    input  logic                            sdram_ack,
    output logic [mem_map_pkg::SDRAM_AW-1:0] prog_addr,
    output logic [7:0]                      prog_data,
    output logic [1:0]                      prog_mask,
    output logic [1:0]                      prog_bank,
    output logic                            prog_we
);
    import mem_map_pkg::*;

    logic             accept;
    logic             is_cpu;
    logic [DL_AW-1:0] rebased;

    // A byte is only taken when no write is still waiting on the SDRAM
    assign accept = downloading && ioctl_wr && !prog_we;

    // CPU program sits in bank 1 from word 0, the rest restarts at 0 in bank 0
    assign is_cpu  = ioctl_addr < CPU_ROM_BYTES;
    assign rebased = is_cpu ? ioctl_addr : ioctl_addr - CPU_ROM_BYTES;

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (prog_we) begin
            if (sdram_ack) begin
                prog_we <= 1'b0;
            end
        end else if (accept) begin
            prog_we <= 1'b1;
        end
    end

    // Write payload, held steady until the acknowledge
    always_ff @(posedge VB) begin
        if (accept) begin
            prog_addr <= rebased[DL_AW-1:1];
            prog_data <= ioctl_data;
            prog_bank <= is_cpu ? 2'b01 : 2'b00;
            // Mask is active low, even bytes land in the low lane
            prog_mask <= rebased[0] ? 2'b01 : 2'b10;
        end
    end

endmodule

//--- logic/frac_cen.sv
// CPU clock-enable generator, pulses cpu_cen for CEN_NUM out of every CEN_DEN cycles of VB
`timescale 1ns/1ps

module frac_cen (
    input  logic VB,
    input  logic rst_n,
    output logic cpu_cen
);
    import mem_map_pkg::*;

    logic [CEN_W-1:0] acc;
    logic [CEN_W:0]   sum;

    // Extra top bit so the sum cannot wrap before the compare
    assign sum = {1'b0, acc} + {1'b0, CEN_NUM};

    // Remainder stays below CEN_DEN, so pulses come out evenly spread
    always_ff @(posedge VB) begin
        if (!rst_n) begin
            acc     <= '0;
            cpu_cen <= 1'b0;
        end else if (sum >= {1'b0, CEN_DEN}) begin
            acc     <= CEN_W'(sum - {1'b0, CEN_DEN});
            cpu_cen <= 1'b1;
        end else begin
            acc     <= sum[CEN_W-1:0];
            cpu_cen <= 1'b0;
        end
    end

endmodule

//--- logic/sdram_slot_pkg.sv
// Slot numbering, client address widths and arbiter states for the SDRAM slot multiplexer
package sdram_slot_pkg;

    // Lower value wins when several slots are pending
    typedef enum logic [1:0] {
        SLOT_CPU_ROM = 2'd0,
        SLOT_RAM     = 2'd1,
        SLOT_GFX     = 2'd2,
        SLOT_SND     = 2'd3
    } slot_e;

    localparam int NUM_SLOTS = 4;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_e;

    // Client address widths, all in SDRAM words
    localparam int ROM_AW = 21;
    localparam int RAM_AW = 17;
    localparam int GFX_AW = 22;
    localparam int SND_AW = 16;

endpackage

//--- logic/mem_map_pkg.sv
// SDRAM memory map, bus widths and CPU clock-enable ratio, imported by every RTL block
package mem_map_pkg;

    // SDRAM port widths
    localparam int SDRAM_AW  = 22;
    localparam int SDRAM_RDW = 32;
    localparam int SDRAM_WDW = 16;

    // Byte address width of the download stream
    localparam int DL_AW = 23;

    // Region bases, in SDRAM words
    localparam logic [SDRAM_AW-1:0] SOUND_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] ADPCM_OFFSET = 22'h00_8000;
    localparam logic [SDRAM_AW-1:0] GFX_OFFSET   = 22'h02_8000;
    localparam logic [SDRAM_AW-1:0] RAM_OFFSET   = 22'h3A_8000;
    localparam logic [SDRAM_AW-1:0] VRAM_OFFSET  = 22'h3B_0000;

    // CPU program leads the download, everything after it goes to bank 0
    localparam logic [DL_AW-1:0] CPU_ROM_BYTES = 23'h10_0000;

    // CPU enable runs at 5/24 of VB
    localparam int              CEN_W   = 10;
    localparam logic [CEN_W-1:0] CEN_NUM = 10'd5;
    localparam logic [CEN_W-1:0] CEN_DEN = 10'd24;

endpackage
